//--- Makefile
VERILATOR := verilator
TB_TOP    := z80FetchTb
RTL_TOP   := z80Fetch
FILELIST  := z80Fetch.f
LINTFLAGS := --lint-only -Wall --timing
SIMFLAGS  := --binary --timing --assert -Wno-fatal
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TB_TOP)
	-./$(OBJDIR)/$(TB_TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- hw/byteAssembler.sv
`timescale 1ns/1ns

module byteAssembler
    import z80Pkg::*;
(
    input logic   clk,
    input logic   rstN,
    fetchIf.store store
);

    // a first byte arrives with clear, so it restarts the count at one
    always_ff @(posedge clk) begin
        if (!rstN) begin
            store.count <= '0;
        end else if (store.clear) begin
            store.count <= store.load ? 3'd1 : 3'd0;
        end else if (store.load) begin
            store.count <= store.count + 3'd1;
        end
    end

    // little-endian, opcode in the low lane and operands above it
    always_ff @(posedge clk) begin
        if (store.clear) begin
            store.bytes <= '0;
            if (store.load) begin
                store.bytes[byteWidth-1:0] <= store.byteIn;
            end
        end else if (store.load) begin
            store.bytes[byteWidth*store.count[1:0] +: byteWidth] <= store.byteIn;
        end
    end

endmodule

//--- hw/fetchCtrl.sv
`timescale 1ns/1ns

module fetchCtrl
    import z80Pkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    fetchIf.ctrl                 fetch,
    output logic                 memRd,
    input  logic [byteWidth-1:0] memData,
    input  logic                 memValid,
    input  logic                 hold,
    input  logic                 redirect,
    input  logic                 needMore,
    input  instrLenT             fullLen,
    output logic                 advance,
    output logic                 markStart,
    output logic                 instrValid
);
    fetchStateT state;
    fetchStateT nextState;
    logic       firstByte;
    logic       discard;
    logic       accept;

    assign accept = (state == stWait) && memValid && !redirect && !discard;
    assign advance = accept;
    assign markStart = accept && firstByte;
    assign memRd = (state == stRequest) && !redirect;
    assign instrValid = (state == stEmit) && !hold && !redirect;

    assign fetch.load = accept;
    assign fetch.clear = redirect || markStart;
    assign fetch.byteIn = memData;

    always_comb begin
        nextState = state;
        case (state)
            stRequest: begin
                if (!redirect) begin
                    nextState = stWait;
                end
            end
            stWait: begin
                if (memValid) begin
                    nextState = accept ? stDecide : stRequest;
                end
            end
            stDecide: begin
                if (redirect || needMore || fetch.count < fullLen) begin
                    nextState = stRequest;
                end else begin
                    nextState = stEmit;
                end
            end
            stEmit: begin
                if (redirect || !hold) begin
                    nextState = stRequest;
                end
            end
            default: nextState = stRequest;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
            firstByte <= 1'b1;
            discard <= 1'b0;
        end else begin
            state <= nextState;
            if (redirect || instrValid) begin
                firstByte <= 1'b1;
            end else if (accept) begin
                firstByte <= 1'b0;
            end
            // a read still in flight at redirect returns stale data, drop it
            if (state == stWait && memValid) begin
                discard <= 1'b0;
            end else if (state == stWait && redirect) begin
                discard <= 1'b1;
            end
        end
    end

    // only one read outstanding at a time
    assert property (@(posedge clk) disable iff (!rstN)
        memRd |=> (!memRd throughout memValid [->1]));

    assert property (@(posedge clk) disable iff (!rstN)
        fetch.count <= maxInstrBytes);

endmodule

//--- hw/fetchIf.sv
`timescale 1ns/1ns

interface fetchIf
    import z80Pkg::*;
();
    logic                  clear;
    logic                  load;
    logic [byteWidth-1:0]  byteIn;
    logic [2:0]            count;
    logic [instrWidth-1:0] bytes;

    modport ctrl (
        output clear, load, byteIn,
        input  count, bytes
    );

    modport store (
        input  clear, load, byteIn,
        output count, bytes
    );
endinterface

//--- hw/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder
    import z80Pkg::*;
(
    input  logic [instrWidth-1:0] bytes,
    input  logic [2:0]            count,
    output insnGroupT             group,
    output instrLenT              fullLen,
    output logic                  needMore
);
    logic [7:0] op0;
    logic [7:0] op1;
    logic [7:0] op3;
    logic       prefixed;
    logic       idxBits;
    logic [1:0] operands;
    insnGroupT  plainGroup;
    insnGroupT  cbGroup;
    insnGroupT  edGroup;
    insnGroupT  ixGroup;
    insnGroupT  bitsGroup;

    assign op0 = bytes[7:0];
    assign op1 = bytes[15:8];
    assign op3 = bytes[31:24];
    assign prefixed = (op0 == prefixCb) || (op0 == prefixDd) ||
                      (op0 == prefixEd) || (op0 == prefixFd);
    assign idxBits = ((op0 == prefixDd) || (op0 == prefixFd)) && (op1 == prefixCb);

    // casez takes the first match, so narrow codes sit above wide patterns
    always_comb begin
        casez (op0)
            8'h00: plainGroup = nop;
            8'b00??_0001: plainGroup = ldDdNn;
            8'b000?_0010: plainGroup = ldIndBcdeA;
            8'b00??_?011: plainGroup = incDecDd;
            8'h34, 8'h35: plainGroup = incDecIndHl;
            8'b00??_?10?: plainGroup = incDecReg;
            8'b000?_?111: plainGroup = rrRlca;
            8'b00??_1001: plainGroup = addHlDd;
            8'h27: plainGroup = daa;
            8'h2F: plainGroup = cpl;
            8'h37: plainGroup = scf;
            8'h3F: plainGroup = ccf;
            8'b000?_1010: plainGroup = ldAIndBcde;
            8'h36: plainGroup = ldIndHlN;
            8'b00??_?110: plainGroup = ldRegN;
            8'h22: plainGroup = ldIndNnHl;
            8'h2A: plainGroup = ldHlIndNn;
            8'h32: plainGroup = ldIndNnA;
            8'h3A: plainGroup = ldAIndNn;
            8'h08: plainGroup = exAfAf2;
            8'h18: plainGroup = jr;
            8'b001?_?000: plainGroup = jrCond;
            8'h76: plainGroup = halt;
            8'b0111_0???: plainGroup = ldIndHlReg;
            8'b01??_?110: plainGroup = illegalInstr;
            8'b01??_????: plainGroup = ldRegReg;
            8'b10??_?110: plainGroup = aluAIndHl;
            8'b10??_????: plainGroup = aluAReg;
            8'hC3: plainGroup = jp;
            8'b11??_?010: plainGroup = jpCond;
            8'hE9: plainGroup = jpIndHl;
            8'hE3: plainGroup = exIndSpHl;
            8'hEB: plainGroup = exDeHl;
            8'hD9: plainGroup = exx;
            8'hF9: plainGroup = ldSpHl;
            8'hF3, 8'hFB: plainGroup = eiDi;
            8'b11??_0001: plainGroup = popQq;
            8'b11??_0101: plainGroup = pushQq;
            8'b11??_?110: plainGroup = aluAN;
            default: plainGroup = illegalInstr;
        endcase
    end

    // sll at CB 30..37 is undocumented and stays illegal
    always_comb begin
        casez (op1)
            8'b000?_?110: cbGroup = rrRlcIndHl;
            8'b000?_????: cbGroup = rrRlcReg;
            8'b0011_0???: cbGroup = illegalInstr;
            8'b001?_?110: cbGroup = shiftIndHl;
            8'b001?_????: cbGroup = shiftReg;
            8'b01??_?110: cbGroup = bitIndHl;
            8'b01??_????: cbGroup = bitReg;
            8'b11??_?110: cbGroup = setIndHl;
            8'b11??_????: cbGroup = setReg;
            8'b10??_?110: cbGroup = resIndHl;
            default: cbGroup = resReg;
        endcase
    end

    always_comb begin
        casez (op1)
            8'h44: edGroup = neg;
            8'h47: edGroup = ldIA;
            8'h4F: edGroup = ldRA;
            8'h57: edGroup = ldAI;
            8'h5F: edGroup = ldAR;
            8'h67, 8'h6F: edGroup = rotDec;
            8'b01??_?010: edGroup = adcSbcHlDd;
            8'b01??_1011: edGroup = ldDdIndNn;
            8'b01??_0011: edGroup = ldIndNnDd;
            8'hA0: edGroup = ldi;
            8'hA1: edGroup = cpi;
            8'hA8: edGroup = ldd;
            8'hA9: edGroup = cpd;
            8'hB0: edGroup = ldir;
            8'hB1: edGroup = cpir;
            8'hB8: edGroup = lddr;
            8'hB9: edGroup = cpdr;
            default: edGroup = illegalInstr;
        endcase
    end

    // IX and IY share one table, the prefix only selects the register
    always_comb begin
        casez (op1)
            8'b00??_1001: ixGroup = addIxiySs;
            8'h23, 8'h2B: ixGroup = incDecIxiy;
            8'h21: ixGroup = ldIxiyNn;
            8'h2A: ixGroup = ldIxiyIndNn;
            8'h22: ixGroup = ldIndNnIxiy;
            8'h34, 8'h35: ixGroup = incDecIdxIxiy;
            8'h36: ixGroup = ldIdxIxiyN;
            8'h76: ixGroup = illegalInstr;
            8'b01??_?110: ixGroup = ldRegIdxIxiy;
            8'b0111_0???: ixGroup = ldIdxIxiyReg;
            8'b10??_?110: ixGroup = aluAIdxIxiy;
            8'hE1: ixGroup = popIxiy;
            8'hE3: ixGroup = exIndSpIxiy;
            8'hE5: ixGroup = pushIxiy;
            8'hE9: ixGroup = jpIndIxiy;
            8'hF9: ixGroup = ldSpIxiy;
            default: ixGroup = illegalInstr;
        endcase
    end

    // third byte is the displacement, the fourth names the operation
    always_comb begin
        casez (op3)
            8'b000?_?110: bitsGroup = rrRlcIdxIxiy;
            8'h26, 8'h2E, 8'h3E: bitsGroup = shiftIdxIxiy;
            8'b01??_?110: bitsGroup = bitIdxIxiy;
            8'b11??_?110: bitsGroup = setIdxIxiy;
            8'b10??_?110: bitsGroup = resIdxIxiy;
            default: bitsGroup = illegalInstr;
        endcase
    end

    always_comb begin
        if (count == 3'd0 || (prefixed && count == 3'd1)) begin
            group = needMoreBytes;
        end else if (idxBits) begin
            group = (count == 3'(maxInstrBytes)) ? bitsGroup : idxIxiyBits;
        end else if (!prefixed) begin
            group = plainGroup;
        end else if (op0 == prefixCb) begin
            group = cbGroup;
        end else if (op0 == prefixEd) begin
            group = edGroup;
        end else begin
            group = ixGroup;
        end
    end

    // immediate and displacement bytes that follow the opcode
    always_comb begin
        case (group)
            ldRegN, ldIndHlN, jr, jrCond, aluAN,
            ldRegIdxIxiy, ldIdxIxiyReg, incDecIdxIxiy, aluAIdxIxiy: operands = 2'd1;
            ldDdNn, ldIndNnHl, ldHlIndNn, ldIndNnA, ldAIndNn, jp, jpCond,
            ldDdIndNn, ldIndNnDd, ldIxiyNn, ldIxiyIndNn, ldIdxIxiyN,
            ldIndNnIxiy: operands = 2'd2;
            default: operands = 2'd0;
        endcase
    end

    assign fullLen = idxBits ? instrLenT'(maxInstrBytes) :
                     (prefixed ? 3'd2 : 3'd1) + {1'b0, operands};
    assign needMore = (group == needMoreBytes) || (group == idxIxiyBits);

endmodule

//--- hw/pcUnit.sv
`timescale 1ns/1ns

module pcUnit
    import z80Pkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 advance,
    input  logic                 markStart,
    input  logic                 redirect,
    input  logic [addrWidth-1:0] redirectAddr,
    output logic [addrWidth-1:0] fetchAddr,
    output logic [addrWidth-1:0] startAddr
);

    // redirect wins over a byte accepted in the same cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchAddr <= '0;
        end else if (redirect) begin
            fetchAddr <= redirectAddr;
        end else if (advance) begin
            fetchAddr <= fetchAddr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (markStart) begin
            startAddr <= fetchAddr;
        end
    end

endmodule

//--- hw/z80Fetch.sv
`timescale 1ns/1ns

module z80Fetch
    import z80Pkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    output logic [addrWidth-1:0]  memAddr,
    output logic                  memRd,
    input  logic [byteWidth-1:0]  memData,
    input  logic                  memValid,
    input  logic                  hold,
    input  logic                  redirect,
    input  logic [addrWidth-1:0]  redirectAddr,
    output logic                  instrValid,
    output logic [instrWidth-1:0] instrBytes,
    output insnGroupT             instrGroup,
    output instrLenT              instrLen,
    output logic [addrWidth-1:0]  instrPc
);
    logic needMore;
    logic advance;
    logic markStart;

    fetchIf fIf ();

    assign instrBytes = fIf.bytes;

    fetchCtrl uCtrl (
        .clk        (clk),
        .rstN       (rstN),
        .fetch      (fIf.ctrl),
        .memRd      (memRd),
        .memData    (memData),
        .memValid   (memValid),
        .hold       (hold),
        .redirect   (redirect),
        .needMore   (needMore),
        .fullLen    (instrLen),
        .advance    (advance),
        .markStart  (markStart),
        .instrValid (instrValid)
    );

    byteAssembler uAsm (
        .clk   (clk),
        .rstN  (rstN),
        .store (fIf.store)
    );

    // the decoder sees the partial instruction as it grows
    instrDecoder uDec (
        .bytes    (fIf.bytes),
        .count    (fIf.count),
        .group    (instrGroup),
        .fullLen  (instrLen),
        .needMore (needMore)
    );

    pcUnit uPc (
        .clk          (clk),
        .rstN         (rstN),
        .advance      (advance),
        .markStart    (markStart),
        .redirect     (redirect),
        .redirectAddr (redirectAddr),
        .fetchAddr    (memAddr),
        .startAddr    (instrPc)
    );

endmodule

//--- hw/z80Pkg.sv
package z80Pkg;

    localparam int addrWidth = 16;
    localparam int byteWidth = 8;
    localparam int maxInstrBytes = 4;
    localparam int instrWidth = byteWidth * maxInstrBytes;

    // first bytes that open a second opcode table
    localparam logic [7:0] prefixCb = 8'hCB;
    localparam logic [7:0] prefixDd = 8'hDD;
    localparam logic [7:0] prefixEd = 8'hED;
    localparam logic [7:0] prefixFd = 8'hFD;

    // total instruction length, 1 to 4
    typedef logic [2:0] instrLenT;

    typedef enum logic [7:0] {
        needMoreBytes,
        illegalInstr,
        // unprefixed opcodes
        nop, ldDdNn, ldIndBcdeA, incDecDd, incDecReg, rrRlca,
        addHlDd, daa, cpl, incDecIndHl, ldAIndBcde, ldRegN,
        ldIndNnHl, ldHlIndNn, ldIndHlN, ldRegReg, ldIndNnA, scf,
        ldAIndNn, ccf, ldIndHlReg, halt, jp, jpCond,
        jpIndHl, jr, jrCond, popQq, pushQq, exAfAf2,
        exIndSpHl, exDeHl, exx, ldSpHl, aluAReg, aluAIndHl,
        aluAN, eiDi,
        // CB table
        rrRlcReg, rrRlcIndHl, shiftReg, shiftIndHl, bitReg, bitIndHl,
        setReg, setIndHl, resReg, resIndHl,
        // ED table
        adcSbcHlDd, ldDdIndNn, neg, ldIndNnDd, ldIA, ldRA,
        ldAI, ldAR, rotDec, ldi, cpi, ldd,
        cpd, ldir, cpir, lddr, cpdr,
        // DD and FD tables
        addIxiySs, incDecIxiy, ldRegIdxIxiy, ldIdxIxiyReg, ldIxiyNn, ldIxiyIndNn,
        incDecIdxIxiy, ldIdxIxiyN, exIndSpIxiy, popIxiy, pushIxiy, ldIndNnIxiy,
        aluAIdxIxiy, jpIndIxiy, ldSpIxiy,
        // DD CB d op and FD CB d op, picked by the fourth byte
        idxIxiyBits, rrRlcIdxIxiy, shiftIdxIxiy, bitIdxIxiy, setIdxIxiy, resIdxIxiy
    } insnGroupT;

    typedef enum logic [2:0] {
        stIdle,
        stRequest,
        stWait,
        stDecide,
        stEmit
    } fetchStateT;

endpackage

//--- tests/z80FetchTb.sv
`timescale 1ns/1ns

module z80FetchTb
    import z80Pkg::*;
();
    localparam int numEntries = 23;
    localparam int maxLatency = 5;
    localparam int holdWindow = 8;
    localparam int cycleLimit = 16 + numEntries * maxInstrBytes * (maxLatency + 3) + 200;
    localparam int modePlain = 0;
    localparam int modeHold = 1;
    localparam int modeRedirect = 2;

    logic                  clk;
    logic                  rstN;
    logic [addrWidth-1:0]  memAddr;
    logic                  memRd;
    logic [byteWidth-1:0]  memData = '0;
    logic                  memValid = 1'b0;
    logic                  hold;
    logic                  redirect;
    logic [addrWidth-1:0]  redirectAddr;
    logic                  instrValid;
    logic [instrWidth-1:0] instrBytes;
    insnGroupT             instrGroup;
    instrLenT              instrLen;
    logic [addrWidth-1:0]  instrPc;

    logic [7:0]            mem [0:65535];
    logic [instrWidth-1:0] tblBytes [numEntries];
    insnGroupT             tblGroup [numEntries];
    instrLenT              tblLen [numEntries];
    logic [addrWidth-1:0]  tblPc [numEntries];
    int                    tblMode [numEntries];
    int                    tblCount = 0;
    logic [addrWidth-1:0]  nextPc = '0;
    logic [31:0]           lcgState = 32'd19251;
    logic                  busy;
    logic [1:0]            waitLeft;
    logic [addrWidth-1:0]  pendAddr;
    int                    cycleCount = 0;

    z80Fetch dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkGroup(input insnGroupT got, input insnGroupT exp);
        if (got !== exp) begin
            failRun($sformatf("[ERROR] instrGroup got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic checkLen(input instrLenT got, input instrLenT exp);
        if (got !== exp) begin
            failRun($sformatf("[ERROR] instrLen got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic checkBytes(input logic [instrWidth-1:0] got, input logic [instrWidth-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("[ERROR] instrBytes got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic checkPc(input logic [addrWidth-1:0] got, input logic [addrWidth-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("[ERROR] instrPc got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic checkAddr(input logic [addrWidth-1:0] got, input logic [addrWidth-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("[ERROR] memAddr got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic checkInstr(input int i);
        checkBytes(instrBytes, tblBytes[i]);
        checkGroup(instrGroup, tblGroup[i]);
        checkLen(instrLen, tblLen[i]);
        checkPc(instrPc, tblPc[i]);
        // fetch address has already moved past the last byte
        checkAddr(memAddr, tblPc[i] + 16'(tblLen[i]));
    endtask

    function automatic logic [1:0] randomLatency();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[17:16];
    endfunction

    // instructions sit back to back unless the entry redirects to a new address
    task automatic addEntry(input logic [instrWidth-1:0] bytes, input insnGroupT group,
                            input instrLenT len, input int mode,
                            input logic [addrWidth-1:0] target);
        logic [addrWidth-1:0] pc;
        int k;
        pc = nextPc;
        if (mode == modeRedirect) begin
            // stray LD HL,nn that the redirect cuts off after its first byte
            mem[pc] = 8'h21;
            mem[pc + 16'd1] = 8'h34;
            mem[pc + 16'd2] = 8'h12;
            pc = target;
        end
        for (k = 0; k < int'(len); k++) begin
            mem[pc + 16'(k)] = bytes[8*k +: 8];
        end
        tblBytes[tblCount] = bytes;
        tblGroup[tblCount] = group;
        tblLen[tblCount] = len;
        tblPc[tblCount] = pc;
        tblMode[tblCount] = mode;
        tblCount++;
        nextPc = pc + 16'(len);
    endtask

    // memory answers one read at a time, 2 to 5 cycles after memRd
    always @(posedge clk) begin
        memValid <= 1'b0;
        if (!rstN) begin
            busy <= 1'b0;
            waitLeft <= '0;
        end else if (busy) begin
            if (memRd) begin
                failRun("memRd issued while a read was still outstanding");
            end
            if (waitLeft == 2'd0) begin
                memValid <= 1'b1;
                memData <= mem[pendAddr];
                busy <= 1'b0;
            end else begin
                waitLeft <= waitLeft - 2'd1;
            end
        end else if (memRd) begin
            busy <= 1'b1;
            pendAddr <= memAddr;
            waitLeft <= randomLatency();
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            failRun("timeout, the instruction table did not finish within the cycle limit");
        end
    end

    initial begin
        int a;
        int i;
        int seen;
        rstN = 1'b0;
        hold = 1'b0;
        redirect = 1'b0;
        redirectAddr = '0;
        for (a = 0; a < 65536; a++) begin
            mem[a] = a[15:8] ^ a[7:0] ^ 8'hA5;
        end
        // bytes little-endian, group, length, mode, redirect target
        addEntry(32'h0000_0000, nop, 3'd1, modePlain, 16'h0);
        addEntry(32'h0000_0041, ldRegReg, 3'd1, modePlain, 16'h0);
        addEntry(32'h0000_0080, aluAReg, 3'd1, modePlain, 16'h0);
        addEntry(32'h0000_0076, halt, 3'd1, modePlain, 16'h0);
        addEntry(32'h0000_00D9, exx, 3'd1, modePlain, 16'h0);
        addEntry(32'h0012_3401, ldDdNn, 3'd3, modePlain, 16'h0);
        addEntry(32'h0010_00C2, jpCond, 3'd3, modePlain, 16'h0);
        addEntry(32'h0000_FE18, jr, 3'd2, modePlain, 16'h0);
        addEntry(32'h0000_05C6, aluAN, 3'd2, modePlain, 16'h0);
        addEntry(32'h0000_40CB, bitReg, 3'd2, modePlain, 16'h0);
        addEntry(32'h0000_B0ED, ldir, 3'd2, modePlain, 16'h0);
        addEntry(32'h2000_4BED, ldDdIndNn, 3'd4, modePlain, 16'h0);
        addEntry(32'h0005_46DD, ldRegIdxIxiy, 3'd3, modePlain, 16'h0);
        addEntry(32'h4605_CBDD, bitIdxIxiy, 3'd4, modePlain, 16'h0);
        addEntry(32'hC610_CBFD, setIdxIxiy, 3'd4, modePlain, 16'h0);
        addEntry(32'h8600_CBDD, resIdxIxiy, 3'd4, modePlain, 16'h0);
        addEntry(32'h4002_CBFD, illegalInstr, 3'd4, modePlain, 16'h0);
        addEntry(32'h0000_00D3, illegalInstr, 3'd1, modePlain, 16'h0);
        addEntry(32'h0000_00ED, illegalInstr, 3'd2, modePlain, 16'h0);
        addEntry(32'h0000_00DD, illegalInstr, 3'd2, modePlain, 16'h0);
        addEntry(32'h3000_21FD, ldIxiyNn, 3'd4, modeHold, 16'h0);
        addEntry(32'h0000_7F3E, ldRegN, 3'd2, modeRedirect, 16'h4000);
        addEntry(32'h0000_003C, incDecReg, 3'd1, modePlain, 16'h0);

        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        for (i = 0; i < numEntries; i++) begin
            if (tblMode[i] == modeHold) begin
                @(posedge clk);
                hold <= 1'b1;
                seen = 0;
                while (seen < int'(tblLen[i])) begin
                    @(negedge clk);
                    if (memValid) begin
                        seen++;
                    end
                end
                // load then decide, after that the controller waits in emit
                repeat (2) @(negedge clk);
                repeat (holdWindow) begin
                    @(negedge clk);
                    if (memRd || instrValid) begin
                        failRun("memRd or instrValid was seen while hold was high");
                    end
                    checkInstr(i);
                end
                @(posedge clk);
                hold <= 1'b0;
            end else if (tblMode[i] == modeRedirect) begin
                do @(negedge clk); while (!memValid);
                do @(negedge clk); while (!memRd);
                // lands while the second stray byte is still outstanding
                @(posedge clk);
                redirect <= 1'b1;
                redirectAddr <= tblPc[i];
                @(posedge clk);
                redirect <= 1'b0;
            end
            do @(negedge clk); while (!instrValid);
            checkInstr(i);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- z80Fetch.f
hw/z80Pkg.sv
hw/fetchIf.sv
hw/instrDecoder.sv
hw/byteAssembler.sv
hw/pcUnit.sv
hw/fetchCtrl.sv
hw/z80Fetch.sv
tests/z80FetchTb.sv
